//--- build.f
design/cnn_weight_pkg.sv
design/weight_fifo.sv
design/weight_load_ctrl.sv
design/weight_bank.sv
design/weight_read_seq.sv
design/weight_buffer_top.sv
tests/weight_buffer_tb.sv

//--- design/cnn_weight_pkg.sv
// ----------------------------------------------------------
// cnn weight package
// tile geometry of the weight buffer and the sizes derived
// from it, shared by the RTL and the testbench
// ----------------------------------------------------------
package cnn_weight_pkg;

    localparam int DW = 16;             // coefficient width
    localparam int K = 3;               // kernel side
    localparam int KERNEL_SIZE = K * K;
    localparam int TM = 2;              // input channel tile
    localparam int TN = 2;              // output channel tile
    localparam int X = 2;               // input channel banks per row
    localparam int Y = 2;               // bank rows
    localparam int NUM_BANKS = X * Y;

    localparam int BLOCK_SIZE = KERNEL_SIZE * TM;        // one output channel
    localparam int WEIGHT_SIZE = KERNEL_SIZE * TM * TN;  // one full load
    localparam int BANK_DEPTH = (TM / X) * (TN / Y) * KERNEL_SIZE;
    localparam int BANK_AW = $clog2(BANK_DEPTH);

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;

    // counter widths for the load controller
    localparam int WCNT_W = $clog2(WEIGHT_SIZE);
    localparam int XW = $clog2(X);
    localparam int YW = $clog2(Y);

endpackage

//--- design/weight_bank.sv
// ----------------------------------------------------------
// weight bank
// coefficient memory of one (output, input) channel pair with
// a self-advancing write pointer and a registered read port
// ----------------------------------------------------------
module weight_bank import cnn_weight_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               wr_en,
    input  logic [DW-1:0]      wr_data,
    input  logic [BANK_AW-1:0] rd_addr,
    output logic [DW-1:0]      rd_data
);

    logic [DW-1:0]      mem [BANK_DEPTH];
    logic [BANK_AW-1:0] wr_ptr;
    logic               has_room;

    assign has_room = wr_ptr < BANK_AW'(BANK_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;          // start of a new load
        end else if (wr_en && has_room) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && has_room) begin
            mem[wr_ptr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

    // a load must not send more than one bank's worth between clears
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> has_room)
        else $error("weight bank written past its depth");

endmodule

//--- design/weight_buffer_top.sv
// ----------------------------------------------------------
// weight buffer top
// fifo, load controller, X by Y grid of weight banks and the
// read sequencer that feeds the compute array
// ----------------------------------------------------------
module weight_buffer_top import cnn_weight_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DW-1:0]           wr_data,
    input  logic                    wr_push,
    input  logic                    load_start,
    input  logic                    rd_start,
    output logic                    fifo_full,
    output logic                    load_done,
    output logic                    rd_valid,
    output logic                    rd_done,
    output logic [NUM_BANKS*DW-1:0] rd_weights
);

    logic [DW-1:0]        fifo_data;
    logic                 fifo_empty;
    logic                 fifo_pop;
    logic [DW-1:0]        bank_wr_data;
    logic [NUM_BANKS-1:0] bank_wr_en;
    logic                 bank_clear;
    logic [BANK_AW-1:0]   rd_addr;    // shared by every bank

    weight_fifo weight_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (wr_push),
        .data_in  (wr_data),
        .pop      (fifo_pop),
        .data_out (fifo_data),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    weight_load_ctrl weight_load_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .load_start   (load_start),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .bank_wr_data (bank_wr_data),
        .bank_wr_en   (bank_wr_en),
        .bank_clear   (bank_clear),
        .load_done    (load_done)
    );

    // bank (o, i) sits in slice o*X+i
    for (genvar o = 0; o < Y; o++) begin : g_row
        for (genvar i = 0; i < X; i++) begin : g_col
            weight_bank weight_bank_i (
                .clk     (clk),
                .rst     (rst),
                .clear   (bank_clear),
                .wr_en   (bank_wr_en[o*X+i]),
                .wr_data (bank_wr_data),
                .rd_addr (rd_addr),
                .rd_data (rd_weights[(o*X+i)*DW +: DW])
            );
        end
    end

    weight_read_seq weight_read_seq_i (
        .clk      (clk),
        .rst      (rst),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_done  (rd_done)
    );

endmodule

//--- design/weight_fifo.sv
// ----------------------------------------------------------
// weight fifo
// first-word-fall-through queue for incoming coefficients,
// the head word is always visible on data_out
// ----------------------------------------------------------
module weight_fifo import cnn_weight_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  logic [DW-1:0] data_in,
    input  logic          pop,
    output logic [DW-1:0] data_out,
    output logic          empty,
    output logic          full
);

    logic [DW-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;     // occupancy, one bit wider than the pointers
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty    = (count == '0);
    assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the writer upstream and the load controller must respect the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("weight fifo pushed while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("weight fifo popped while empty");

endmodule

//--- design/weight_load_ctrl.sv
// ----------------------------------------------------------
// weight load controller
// drains the fifo during a load and steers each coefficient
// to its bank, kernel by kernel and row by row
// ----------------------------------------------------------
module weight_load_ctrl import cnn_weight_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_start,
    input  logic [DW-1:0]        fifo_data,
    input  logic                 fifo_empty,
    output logic                 fifo_pop,
    output logic [DW-1:0]        bank_wr_data,
    output logic [NUM_BANKS-1:0] bank_wr_en,
    output logic                 bank_clear,
    output logic                 load_done
);

    logic              load_active;
    logic [WCNT_W-1:0] word_cnt;     // words popped so far in this load
    logic [XW-1:0]     in_idx;       // input channel bank
    logic [YW-1:0]     out_idx;      // output channel row
    logic              kernel_end;
    logic              block_end;
    logic              last_word;
    logic              last_wr;      // write of the final word is in flight

    assign fifo_pop   = load_active && !fifo_empty;
    assign kernel_end = (int'(word_cnt) % KERNEL_SIZE) == KERNEL_SIZE - 1;
    assign block_end  = (int'(word_cnt) % BLOCK_SIZE) == BLOCK_SIZE - 1;
    assign last_word  = word_cnt == WCNT_W'(WEIGHT_SIZE - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_active <= 1'b0;
            word_cnt    <= '0;
            in_idx      <= '0;
            out_idx     <= '0;
        end else if (load_start) begin
            load_active <= 1'b1;
            word_cnt    <= '0;
            in_idx      <= '0;
            out_idx     <= '0;
        end else if (fifo_pop) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) load_active <= 1'b0;
            if (kernel_end) in_idx <= (in_idx == XW'(X - 1)) ? '0 : in_idx + 1'b1;
            if (block_end)  out_idx <= (out_idx == YW'(Y - 1)) ? '0 : out_idx + 1'b1;
        end
    end

    // popped word and its one-hot bank select, written one edge later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_wr_en <= '0;
            bank_clear <= 1'b0;
            last_wr    <= 1'b0;
            load_done  <= 1'b0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_wr_en[b] <= fifo_pop && (b == int'(out_idx) * X + int'(in_idx));
            end
            bank_clear <= load_start;     // rewinds all write pointers
            last_wr    <= fifo_pop && last_word;
            load_done  <= last_wr;        // last word is in its bank by now
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) bank_wr_data <= fifo_data;
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        load_start |-> !load_active)
        else $error("load_start seen while a load is in progress");

endmodule

//--- design/weight_read_seq.sv
// ----------------------------------------------------------
// weight read sequencer
// sweeps every bank through all addresses in lock step and
// flags the beats once the bank read latency has passed
// ----------------------------------------------------------
module weight_read_seq import cnn_weight_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_start,
    output logic [BANK_AW-1:0] rd_addr,
    output logic               rd_valid,
    output logic               rd_done
);

    logic active;
    logic last_addr;

    assign last_addr = rd_addr == BANK_AW'(BANK_DEPTH - 1);

    // address counter, 0 to BANK_DEPTH-1 once per sweep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            rd_addr <= '0;
        end else if (rd_start) begin
            active  <= 1'b1;
            rd_addr <= '0;
        end else if (active) begin
            if (last_addr) begin
                active  <= 1'b0;
                rd_addr <= '0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // match the registered read port of the banks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            rd_valid <= active;
            rd_done  <= active && last_addr;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst) rd_start |-> !active)
        else $error("rd_start seen while a sweep is active");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the weight buffer testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module weight_buffer_tb \
        -Mdir obj_dir -o weight_buffer_sim; then
    echo "verilator build returned an error"
    exit 1
fi

./obj_dir/weight_buffer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
exit 1

//--- tests/weight_buffer_tb.sv
// ----------------------------------------------------------
// weight buffer testbench
// loads coefficients three ways and checks every read sweep
// ----------------------------------------------------------
module weight_buffer_tb import cnn_weight_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    rst;
    logic [DW-1:0]           wr_data;
    logic                    wr_push;
    logic                    load_start;
    logic                    rd_start;
    logic                    fifo_full;
    logic                    load_done;
    logic                    rd_valid;
    logic                    rd_done;
    logic [NUM_BANKS*DW-1:0] rd_weights;

    logic [DW-1:0] words [WEIGHT_SIZE];          // coefficients of the current load
    logic [DW-1:0] model [Y][X][BANK_DEPTH];     // expected bank contents
    integer        seed;
    int            done_pulses = 0;
    int            cycles = 0;
    int            checks = 0;
    int            errors = 0;

    weight_buffer_top weight_buffer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // load_done is sampled before the edge updates it
    always @(posedge clk) begin
        if (load_done) done_pulses <= done_pulses + 1;
        cycles <= cycles + 1;
        if (cycles == 4 * (2 * WEIGHT_SIZE + 2 * BANK_DEPTH) + 200) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0d ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_word(input string name, input logic [DW-1:0] exp,
                                input logic [DW-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // word n goes to input bank (n/KERNEL_SIZE)%X of output row (n/BLOCK_SIZE)%Y
    task automatic build_model();
        int fill [Y][X];
        int o;
        int i;
        foreach (fill[a, b]) fill[a][b] = 0;
        for (int n = 0; n < WEIGHT_SIZE; n++) begin
            i = (n / KERNEL_SIZE) % X;
            o = (n / BLOCK_SIZE) % Y;
            model[o][i][fill[o][i]] = words[n];
            fill[o][i]++;
        end
    endtask

    task automatic pulse_load_start();
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
    endtask

    task automatic push_word(input logic [DW-1:0] w);
        while (fifo_full) @(negedge clk);    // writer holds off on full
        wr_data = w;
        wr_push = 1'b1;
        @(negedge clk);
        wr_push = 1'b0;
    endtask

    // mode 0 back to back, mode 1 random gaps, mode 2 fill the fifo first
    task automatic run_load(input int mode);
        int base;
        int gap;
        base = done_pulses;
        if (mode != 2) pulse_load_start();
        for (int n = 0; n < WEIGHT_SIZE; n++) begin
            if (mode == 2 && n == FIFO_DEPTH) begin
                compare_bit("fifo_full", 1'b1, fifo_full);    // writer pauses from here
                pulse_load_start();
            end
            if (mode == 1) begin
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
            end
            if (mode == 0) compare_bit("fifo_full", 1'b0, fifo_full);
            push_word(words[n]);
        end
        checks++;
        assert (done_pulses == base) else begin
            errors++;
            $display("load_done pulsed before the last word was pushed");
        end
        while (done_pulses == base) @(negedge clk);
        repeat (4) @(negedge clk);
        checks++;
        assert (done_pulses == base + 1) else begin
            errors++;
            $display("load_done pulsed %0d times in one load, expected once", done_pulses - base);
        end
    endtask

    task automatic read_back();
        rd_start = 1'b1;
        @(negedge clk);
        rd_start = 1'b0;
        compare_bit("rd_valid", 1'b0, rd_valid);    // address 0 is at the banks now
        compare_bit("rd_done", 1'b0, rd_done);
        for (int a = 0; a < BANK_DEPTH; a++) begin
            @(negedge clk);
            compare_bit("rd_valid", 1'b1, rd_valid);
            compare_bit("rd_done", a == BANK_DEPTH - 1, rd_done);
            for (int o = 0; o < Y; o++) begin
                for (int i = 0; i < X; i++) begin
                    compare_word($sformatf("rd_weights[%0d] addr %0d", o * X + i, a),
                                 model[o][i][a], rd_weights[(o * X + i) * DW +: DW]);
                end
            end
        end
        @(negedge clk);
        compare_bit("rd_valid", 1'b0, rd_valid);
        compare_bit("rd_done", 1'b0, rd_done);
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s: %s (%0d errors)", name, (errors == mark) ? "ok" : "FAIL",
                 errors - mark);
    endtask

    initial begin
        int mark;
        rst        = 1'b1;
        wr_data    = '0;
        wr_push    = 1'b0;
        load_start = 1'b0;
        rd_start   = 1'b0;
        seed       = 32'h9a015c92;
        $readmemh("tests/weight_buffer_tests.txt", words);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        mark = errors;
        compare_bit("fifo_full", 1'b0, fifo_full);
        compare_bit("load_done", 1'b0, load_done);
        compare_bit("rd_valid", 1'b0, rd_valid);
        compare_bit("rd_done", 1'b0, rd_done);
        report_test("reset state", mark);

        mark = errors;
        build_model();
        run_load(0);
        report_test("file load", mark);
        mark = errors;
        read_back();
        report_test("file read-back", mark);

        // fifo drains between gaps so the load stalls
        mark = errors;
        for (int n = 0; n < WEIGHT_SIZE; n++) words[n] = DW'($random(seed));
        build_model();
        run_load(1);
        read_back();
        report_test("stalled random load", mark);

        mark = errors;
        for (int n = 0; n < WEIGHT_SIZE; n++) words[n] = DW'($random(seed));
        build_model();
        run_load(2);
        read_back();
        report_test("prefilled load", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tests/weight_buffer_tests.txt
// first load: one 16-bit coefficient per line in hex, word 0 first
// nine words per kernel, 36 words in all
// kernel 0: output row 0, input bank 0
0a13
f2c4
0071
3e8d
9b20
4c55
d107
0e6a
7f31
// kernel 1: output row 0, input bank 1
12fe
8834
c5a9
0003
6d71
b2e0
39c8
e41f
5a96
// kernel 2: output row 1, input bank 0
fffe
0100
7ab3
2d4c
96e5
c01d
4f72
0b89
e3a6
// kernel 3: output row 1, input bank 1
5c17
a4d0
183b
72f9
0dc2
b96e
8000
3f45
c7ab
